// ==== cpu_bus_top.f ====
design/cpu_bus_pkg.sv
design/lane_steer.sv
design/clint_timer.sv
design/bus_arbiter.sv
design/axi_sram.sv
design/cpu_bus_top.sv
tests/cpu_bus_tb.sv

// ==== Makefile ====
# Verilator build and run for the cpu bus testbench

VERILATOR ?= verilator
TOP       ?= cpu_bus_top_tb
FILELIST  ?= cpu_bus_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j $(JOBS)
PASS_MSG  := Simulation finished: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then echo "run passed"; \
	else echo "run failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/cpu_bus_tb.sv ====
`timescale 1ns/100ps

module cpu_bus_top_tb;

  localparam int CLK_NS      = 8;
  localparam int RESET_CYC   = 16;
  localparam int RESP_LIMIT  = 16;  // cycles before a request counts as lost
  localparam int N_TESTS     = 5;
  localparam int MAX_TXN     = 32;  // per test
  localparam int WATCHDOG_NS = N_TESTS * MAX_TXN * 4 * CLK_NS + 4000;
  localparam int N_WORDS     = 8;
  localparam logic [31:0]        LFSR_TAPS = 32'h8020_0003;
  localparam cpu_bus_pkg::addr_t SRAM_BASE = 32'h8000_0000;

  logic                  clk;
  logic                  rst;
  logic                  ifu_valid;
  cpu_bus_pkg::addr_t    ifu_addr;
  logic                  ifu_rvalid_o;
  cpu_bus_pkg::word_t    ifu_rdata_o;
  logic                  lsu_valid;
  cpu_bus_pkg::lsu_req_t lsu_req;
  logic                  lsu_rvalid_o;
  cpu_bus_pkg::word_t    lsu_rdata_o;
  logic                  lsu_wdone_o;

  cpu_bus_pkg::word_t exp_ifu, exp_lsu;
  logic               chk_lsu, race;
  logic [31:0]        lfsr = 32'h7baa_2c68;
  logic [7:0]         model [4096];  // byte image of the sram indexed by addr[11:0]
  string              test_name = "reset";
  int cyc = 0, wdone_cnt = 0, stores = 0, err_mark = 0, tests_run = 0, tests_failed = 0;
  int err_ifu_idle = 0, err_lsu_idle = 0, err_wd_single = 0, err_wd_kind = 0;
  int err_ifu_data = 0, err_lsu_data = 0, err_order = 0, err_proc = 0;

  cpu_bus_top cpu_bus_top_inst (
    .clk (clk), .rst (rst),
    .ifu_valid_i (ifu_valid), .ifu_addr_i (ifu_addr),
    .ifu_rvalid_o (ifu_rvalid_o), .ifu_rdata_o (ifu_rdata_o),
    .lsu_valid_i (lsu_valid), .lsu_req_i (lsu_req),
    .lsu_rvalid_o (lsu_rvalid_o), .lsu_rdata_o (lsu_rdata_o), .lsu_wdone_o (lsu_wdone_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk) cyc++;
  always @(negedge clk) if (!rst && lsu_wdone_o) wdone_cnt++;  // strobe counted mid-cycle

  a_ifu_idle: assert property (@(posedge clk) disable iff (rst) !ifu_valid |-> !ifu_rvalid_o)
    else begin
      $display("fetch response without a fetch request in %s", test_name);
      err_ifu_idle++;
    end
  a_lsu_idle: assert property (@(posedge clk) disable iff (rst)
      !lsu_valid |-> !(lsu_rvalid_o || lsu_wdone_o))
    else begin
      $display("lsu response without an lsu request in %s", test_name);
      err_lsu_idle++;
    end
  a_wd_single: assert property (@(posedge clk) disable iff (rst) lsu_wdone_o |=> !lsu_wdone_o)
    else begin
      $display("store done strobe longer than one cycle in %s", test_name);
      err_wd_single++;
    end
  a_wd_kind: assert property (@(posedge clk) disable iff (rst) lsu_wdone_o |-> lsu_req.write)
    else begin
      $display("store done strobe for a load in %s", test_name);
      err_wd_kind++;
    end
  a_ifu_data: assert property (@(posedge clk) disable iff (rst)
      ifu_rvalid_o |-> ifu_rdata_o == exp_ifu)
    else begin
      $display("[FAIL] %s: fetch data expected %h actual %h", test_name,
               $sampled(exp_ifu), $sampled(ifu_rdata_o));
      err_ifu_data++;
    end
  a_lsu_data: assert property (@(posedge clk) disable iff (rst)
      lsu_rvalid_o && chk_lsu |-> lsu_rdata_o == exp_lsu)
    else begin
      $display("[FAIL] %s: load data expected %h actual %h", test_name,
               $sampled(exp_lsu), $sampled(lsu_rdata_o));
      err_lsu_data++;
    end
  a_ifu_first: assert property (@(posedge clk) disable iff (rst)
      race && lsu_rvalid_o |-> !ifu_valid)
    else begin
      $display("lsu answered before the fetch in %s", test_name);
      err_order++;
    end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic cpu_bus_pkg::addr_t rand_addr(input logic lane);
    return SRAM_BASE | (rand_bits(9) << 3) | {29'd0, lane, 2'b00};
  endfunction

  function automatic int total_errors();
    return err_ifu_idle + err_lsu_idle + err_wd_single + err_wd_kind + err_ifu_data
         + err_lsu_data + err_order + err_proc;
  endfunction

  function automatic cpu_bus_pkg::word_t model_word(input cpu_bus_pkg::addr_t a);
    logic [11:0] b;
    b = {a[11:2], 2'b00};
    return {model[b + 12'd3], model[b + 12'd2], model[b + 12'd1], model[b]};
  endfunction

  // bytes past the top of the word are dropped like the truncated strobe
  task automatic model_store(input cpu_bus_pkg::addr_t a, input cpu_bus_pkg::access_size_e sz,
                             input cpu_bus_pkg::word_t wd);
    int nbytes;
    int off;
    nbytes = (sz == cpu_bus_pkg::SIZE_BYTE) ? 1 : ((sz == cpu_bus_pkg::SIZE_HALF) ? 2 : 4);
    off    = int'(a[1:0]);
    for (int k = 0; k < nbytes; k++) begin
      if (off + k < 4) model[{a[11:2], 2'b00} + 12'(off + k)] = wd[8 * k +: 8];
    end
  endtask

  task automatic check_latency(input int lat);
    assert (lat <= 4) else begin
      $display("[FAIL] %s: latency expected <= 4 actual %0d", test_name, lat);
      err_proc++;
    end
  endtask

  task automatic fetch(input cpu_bus_pkg::addr_t a, input cpu_bus_pkg::word_t exp, output int lat);
    @(posedge clk);
    ifu_valid <= 1'b1;
    ifu_addr  <= a;
    exp_ifu   <= exp;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!ifu_rvalid_o && lat < RESP_LIMIT);
    if (!ifu_rvalid_o) begin
      $display("no fetch response from address %h in %s", a, test_name);
      err_proc++;
    end
    @(posedge clk);
    ifu_valid <= 1'b0;
  endtask

  task automatic lsu_access(input cpu_bus_pkg::addr_t a, input cpu_bus_pkg::access_size_e sz,
                            input logic wr, input cpu_bus_pkg::word_t wd,
                            input cpu_bus_pkg::word_t exp, input logic chk,
                            output cpu_bus_pkg::word_t rd, output int lat, output int at);
    @(posedge clk);
    lsu_valid <= 1'b1;
    lsu_req   <= '{addr: a, size: sz, write: wr, wdata: wd};
    exp_lsu   <= exp;
    chk_lsu   <= chk;
    if (wr) stores++;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!(wr ? lsu_wdone_o : lsu_rvalid_o) && lat < RESP_LIMIT);
    if (!(wr ? lsu_wdone_o : lsu_rvalid_o)) begin
      $display("no lsu response from address %h in %s", a, test_name);
      err_proc++;
    end
    rd = lsu_rdata_o;
    at = cyc;
    @(posedge clk);
    lsu_valid <= 1'b0;
  endtask

  task automatic store(input cpu_bus_pkg::addr_t a, input cpu_bus_pkg::access_size_e sz,
                       input cpu_bus_pkg::word_t wd);
    cpu_bus_pkg::word_t rd;
    int lat;
    int at;
    lsu_access(a, sz, 1'b1, wd, '0, 1'b0, rd, lat, at);
    model_store(a, sz, wd);
    check_latency(lat);
  endtask

  task automatic load(input cpu_bus_pkg::addr_t a);
    cpu_bus_pkg::word_t rd;
    int lat;
    int at;
    lsu_access(a, cpu_bus_pkg::SIZE_WORD, 1'b0, '0, model_word(a), 1'b1, rd, lat, at);
    check_latency(lat);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = total_errors();
  endtask

  task automatic end_test;
    int n;
    assert (wdone_cnt == stores) else begin
      $display("[FAIL] %s: store done pulses expected %0d actual %0d", test_name,
               stores, wdone_cnt);
      err_proc++;
    end
    n = total_errors() - err_mark;
    tests_run++;
    if (n != 0) tests_failed++;
    $display("test %s %s (%0d errors)", test_name, (n == 0) ? "ok" : "failed", n);
  endtask

  initial begin
    cpu_bus_pkg::addr_t addrs [N_WORDS];
    cpu_bus_pkg::addr_t a, b;
    cpu_bus_pkg::word_t d1, d2;
    int lat_i, lat_l, c1, c2;
    rst       = 1'b1;
    ifu_valid = 1'b0;
    ifu_addr  = '0;
    lsu_valid = 1'b0;
    lsu_req   = '0;
    exp_ifu   = '0;
    exp_lsu   = '0;
    chk_lsu   = 1'b0;
    race      = 1'b0;
    repeat (RESET_CYC) @(posedge clk);
    rst <= 1'b0;

    begin_test("idle_and_store");
    repeat (20) @(posedge clk);
    store(rand_addr(1'b0), cpu_bus_pkg::SIZE_WORD, rand_bits(32));
    end_test();

    begin_test("word_rw");
    for (int i = 0; i < N_WORDS; i++) begin
      addrs[i] = rand_addr(i[0]);  // alternate lanes
      store(addrs[i], cpu_bus_pkg::SIZE_WORD, rand_bits(32));
    end
    for (int i = 0; i < N_WORDS; i++) begin
      fetch(addrs[i], model_word(addrs[i]), lat_i);
      check_latency(lat_i);
      load(addrs[i]);
    end
    end_test();

    begin_test("byte_half_merge");
    for (int i = 0; i < N_WORDS; i++) begin
      a = rand_addr(i[0]);
      store(a, cpu_bus_pkg::SIZE_WORD, rand_bits(32));
      store(a + rand_bits(2), cpu_bus_pkg::SIZE_BYTE, rand_bits(32));
      store(a + (rand_bits(1) << 1), cpu_bus_pkg::SIZE_HALF, rand_bits(32));
      load(a);
    end
    end_test();

    begin_test("mtime_read");
    lsu_access(cpu_bus_pkg::MTIME_LO_ADDR, cpu_bus_pkg::SIZE_WORD, 1'b0, '0, '0, 1'b0,
               d1, lat_l, c1);
    repeat (rand_bits(3)) @(posedge clk);
    lsu_access(cpu_bus_pkg::MTIME_LO_ADDR, cpu_bus_pkg::SIZE_WORD, 1'b0, '0, '0, 1'b0,
               d2, lat_l, c2);
    assert (d2 - d1 == cpu_bus_pkg::word_t'(c2 - c1)) else begin
      $display("[FAIL] %s: mtime step expected %0d actual %0d", test_name, c2 - c1, d2 - d1);
      err_proc++;
    end
    lsu_access(cpu_bus_pkg::MTIME_HI_ADDR, cpu_bus_pkg::SIZE_WORD, 1'b0, '0, 32'd0, 1'b1,
               d1, lat_l, c1);
    end_test();

    begin_test("fetch_priority");
    for (int i = 0; i < 4; i++) begin
      a = rand_addr(1'b0);
      b = rand_addr(1'b1);
      store(a, cpu_bus_pkg::SIZE_WORD, rand_bits(32));
      store(b, cpu_bus_pkg::SIZE_WORD, rand_bits(32));
      race <= 1'b1;
      fork
        fetch(a, model_word(a), lat_i);
        lsu_access(b, cpu_bus_pkg::SIZE_WORD, 1'b0, '0, model_word(b), 1'b1, d1, lat_l, c1);
      join
      race <= 1'b0;
      check_latency(lat_i);
      check_latency(lat_l);
    end
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns in %s", WATCHDOG_NS, test_name);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== design/cpu_bus_top.sv ====
`timescale 1ns/100ps

module cpu_bus_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ifu_valid_i,
  input  cpu_bus_pkg::addr_t    ifu_addr_i,
  output logic                  ifu_rvalid_o,
  output cpu_bus_pkg::word_t    ifu_rdata_o,
  input  logic                  lsu_valid_i,
  input  cpu_bus_pkg::lsu_req_t lsu_req_i,
  output logic                  lsu_rvalid_o,
  output cpu_bus_pkg::word_t    lsu_rdata_o,
  output logic                  lsu_wdone_o
);

  cpu_bus_pkg::axi_ar_t ar;
  cpu_bus_pkg::axi_aw_t aw;
  cpu_bus_pkg::axi_w_t  w;
  cpu_bus_pkg::axi_r_t  r;
  cpu_bus_pkg::axi_b_t  b;
  logic arvalid, arready, awvalid, awready, wvalid, wready, rvalid, bvalid;

  logic               tmr_rd, tmr_hi, tmr_rvalid;
  cpu_bus_pkg::word_t tmr_rdata;

  bus_arbiter arbiter_inst (
    .clk          (clk),
    .rst          (rst),
    .ifu_valid_i  (ifu_valid_i),
    .ifu_addr_i   (ifu_addr_i),
    .ifu_rvalid_o (ifu_rvalid_o),
    .ifu_rdata_o  (ifu_rdata_o),
    .lsu_valid_i  (lsu_valid_i),
    .lsu_req_i    (lsu_req_i),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .lsu_wdone_o  (lsu_wdone_o),
    .ar_o         (ar),
    .arvalid_o    (arvalid),
    .arready_i    (arready),
    .aw_o         (aw),
    .awvalid_o    (awvalid),
    .awready_i    (awready),
    .w_o          (w),
    .wvalid_o     (wvalid),
    .wready_i     (wready),
    .r_i          (r),
    .rvalid_i     (rvalid),
    .b_i          (b),
    .bvalid_i     (bvalid),
    .tmr_rd_o     (tmr_rd),
    .tmr_hi_o     (tmr_hi),
    .tmr_rvalid_i (tmr_rvalid),
    .tmr_rdata_i  (tmr_rdata)
  );

  clint_timer timer_inst (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (tmr_rd),
    .hi_i     (tmr_hi),
    .rvalid_o (tmr_rvalid),
    .rdata_o  (tmr_rdata)
  );

  axi_sram sram_inst (
    .clk       (clk),
    .rst       (rst),
    .ar_i      (ar),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .aw_i      (aw),
    .awvalid_i (awvalid),
    .awready_o (awready),
    .w_i       (w),
    .wvalid_i  (wvalid),
    .wready_o  (wready),
    .r_o       (r),
    .rvalid_o  (rvalid),
    .b_o       (b),
    .bvalid_o  (bvalid)
  );

endmodule

// ==== design/axi_sram.sv ====
`timescale 1ns/100ps

module axi_sram (
  input  logic                 clk,
  input  logic                 rst,
  input  cpu_bus_pkg::axi_ar_t ar_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  input  cpu_bus_pkg::axi_aw_t aw_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  cpu_bus_pkg::axi_w_t  w_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  output cpu_bus_pkg::axi_r_t  r_o,
  output logic                 rvalid_o,
  output cpu_bus_pkg::axi_b_t  b_o,
  output logic                 bvalid_o
);

  localparam int IDX_MSB = cpu_bus_pkg::SRAM_WORD_BITS + 2;

  cpu_bus_pkg::bus_beat_u mem [cpu_bus_pkg::SRAM_WORDS];

  logic ar_fire, aw_fire, w_fire;
  logic aw_held, w_held;       // channel already taken, waiting for the other
  logic wr_go;

  cpu_bus_pkg::axi_aw_t   aw_q;
  cpu_bus_pkg::axi_w_t    w_q;
  cpu_bus_pkg::axi_aw_t   wr_aw;
  cpu_bus_pkg::axi_w_t    wr_w;
  cpu_bus_pkg::bus_beat_u rdata_q;
  logic [3:0]             rid_q;
  logic [3:0]             bid_q;

  // ready in idle, low only while the response is out
  assign arready_o = !rvalid_o;
  assign awready_o = !aw_held && !bvalid_o;
  assign wready_o  = !w_held && !bvalid_o;

  assign ar_fire = arvalid_i && arready_o;
  assign aw_fire = awvalid_i && awready_o;
  assign w_fire  = wvalid_i && wready_o;

  assign wr_go = (aw_held || aw_fire) && (w_held || w_fire);
  assign wr_aw = aw_held ? aw_q : aw_i;
  assign wr_w  = w_held ? w_q : w_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
    end else begin
      rvalid_o <= ar_fire; // rready is tied high upstream
      bvalid_o <= wr_go;
      if (wr_go) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
      end else begin
        if (aw_fire) aw_held <= 1'b1;
        if (w_fire)  w_held  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) aw_q <= aw_i;
    if (w_fire)  w_q  <= w_i;
    if (wr_go) begin
      bid_q <= wr_aw.id;
      for (int i = 0; i < 8; i++) begin
        if (wr_w.strb[i]) mem[wr_aw.addr[IDX_MSB:3]].bytes[i] <= wr_w.data.bytes[i];
      end
    end
    if (ar_fire) begin
      rdata_q <= mem[ar_i.addr[IDX_MSB:3]];
      rid_q   <= ar_i.id;
    end
  end

  assign r_o = '{data: rdata_q, resp: cpu_bus_pkg::AXI_RESP_OKAY, last: 1'b1, id: rid_q};
  assign b_o = '{resp: cpu_bus_pkg::AXI_RESP_OKAY, id: bid_q};

endmodule

// ==== design/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  // fetch port
  input  logic                  ifu_valid_i,
  input  cpu_bus_pkg::addr_t    ifu_addr_i,
  output logic                  ifu_rvalid_o,
  output cpu_bus_pkg::word_t    ifu_rdata_o,
  // load/store port
  input  logic                  lsu_valid_i,
  input  cpu_bus_pkg::lsu_req_t lsu_req_i,
  output logic                  lsu_rvalid_o,
  output cpu_bus_pkg::word_t    lsu_rdata_o,
  output logic                  lsu_wdone_o,
  // axi master
  output cpu_bus_pkg::axi_ar_t  ar_o,
  output logic                  arvalid_o,
  input  logic                  arready_i,
  output cpu_bus_pkg::axi_aw_t  aw_o,
  output logic                  awvalid_o,
  input  logic                  awready_i,
  output cpu_bus_pkg::axi_w_t   w_o,
  output logic                  wvalid_o,
  input  logic                  wready_i,
  input  cpu_bus_pkg::axi_r_t   r_i,
  input  logic                  rvalid_i,
  input  cpu_bus_pkg::axi_b_t   b_i,
  input  logic                  bvalid_i,
  // timer read port
  output logic                  tmr_rd_o,
  output logic                  tmr_hi_o,
  input  logic                  tmr_rvalid_i,
  input  cpu_bus_pkg::word_t    tmr_rdata_i
);

  typedef enum logic [2:0] {IDLE, IF_RD, LS_RD, LS_WR, TIMER_RD} state_e;

  state_e state, state_next;
  state_e owner;    // granted port, valid already in IDLE
  logic   is_mtime;
  logic   sel_ifu;
  logic   r_ours, b_ours;
  logic   ar_done, aw_done, w_done;

  logic [2:0]             axsize;
  logic [7:0]             wstrb;
  cpu_bus_pkg::bus_beat_u wbeat;
  cpu_bus_pkg::word_t     rword;

  assign is_mtime = (lsu_req_i.addr == cpu_bus_pkg::MTIME_LO_ADDR) ||
                    (lsu_req_i.addr == cpu_bus_pkg::MTIME_HI_ADDR);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (ifu_valid_i) begin
          state_next = IF_RD; // fetch has priority
        end else if (lsu_valid_i) begin
          if (lsu_req_i.write)
            state_next = LS_WR;
          else if (is_mtime)
            state_next = TIMER_RD;
          else
            state_next = LS_RD;
        end
      end
      IF_RD, LS_RD: if (r_ours) state_next = IDLE;
      LS_WR:        if (b_ours) state_next = IDLE;
      TIMER_RD:     if (tmr_rvalid_i) state_next = IDLE;
      default:      state_next = IDLE;
    endcase
  end

  assign owner   = (state == IDLE) ? state_next : state;
  assign sel_ifu = (owner == IF_RD);
  assign r_ours  = rvalid_i && (r_i.id == cpu_bus_pkg::AXI_ID_CORE);
  assign b_ours  = bvalid_i && (b_i.id == cpu_bus_pkg::AXI_ID_CORE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      ar_done <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      state <= state_next;
      if (state_next == IDLE) begin
        ar_done <= 1'b0;
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end else begin
        if (arvalid_o && arready_i) ar_done <= 1'b1;
        if (awvalid_o && awready_i) aw_done <= 1'b1; // aw and w finish apart
        if (wvalid_o && wready_i)   w_done  <= 1'b1;
      end
    end
  end

  lane_steer steer_inst (
    .addr_i   (sel_ifu ? ifu_addr_i : lsu_req_i.addr),
    .size_i   (sel_ifu ? cpu_bus_pkg::SIZE_WORD : lsu_req_i.size),
    .wdata_i  (lsu_req_i.wdata),
    .beat_i   (r_i.data),
    .axsize_o (axsize),
    .wbeat_o  (wbeat),
    .wstrb_o  (wstrb),
    .rword_o  (rword)
  );

  assign ar_o.addr  = sel_ifu ? ifu_addr_i : lsu_req_i.addr;
  assign ar_o.len   = cpu_bus_pkg::AXI_LEN_SINGLE;
  assign ar_o.size  = axsize;
  assign ar_o.burst = cpu_bus_pkg::AXI_BURST_INCR;
  assign ar_o.id    = cpu_bus_pkg::AXI_ID_CORE;
  assign arvalid_o  = ((owner == IF_RD) || (owner == LS_RD)) && !ar_done;

  assign aw_o.addr  = lsu_req_i.addr;
  assign aw_o.len   = cpu_bus_pkg::AXI_LEN_SINGLE;
  assign aw_o.size  = axsize;
  assign aw_o.burst = cpu_bus_pkg::AXI_BURST_INCR;
  assign aw_o.id    = cpu_bus_pkg::AXI_ID_CORE;
  assign awvalid_o  = (owner == LS_WR) && !aw_done;

  assign w_o.data = wbeat;
  assign w_o.strb = wstrb;
  assign w_o.last = 1'b1; // single beat only
  assign wvalid_o = (owner == LS_WR) && !w_done;

  // timer strobe only in the entry cycle
  assign tmr_rd_o = (state == TIMER_RD) && !tmr_rvalid_i;
  assign tmr_hi_o = lsu_req_i.addr[2];

  assign ifu_rvalid_o = (state == IF_RD) && r_ours;
  assign ifu_rdata_o  = rword;
  assign lsu_rvalid_o = ((state == LS_RD) && r_ours) || ((state == TIMER_RD) && tmr_rvalid_i);
  assign lsu_rdata_o  = (state == TIMER_RD) ? tmr_rdata_i : rword;
  assign lsu_wdone_o  = (state == LS_WR) && b_ours;

endmodule

// ==== design/clint_timer.sv ====
`timescale 1ns/100ps

module clint_timer (
  input  logic               clk,
  input  logic               rst,
  input  logic               rd_i,
  input  logic               hi_i,
  output logic               rvalid_o,
  output cpu_bus_pkg::word_t rdata_o
);

  logic [63:0] mtime;

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime    <= '0;
      rvalid_o <= 1'b0;
    end else begin
      mtime    <= mtime + 64'd1; // free running, one tick per clk
      rvalid_o <= rd_i;
    end
  end

  // value sampled in the strobe cycle
  always_ff @(posedge clk) begin
    if (rd_i) begin
      rdata_o <= hi_i ? mtime[63:32] : mtime[31:0];
    end
  end

endmodule

// ==== design/lane_steer.sv ====
`timescale 1ns/100ps

module lane_steer (
  input  cpu_bus_pkg::addr_t        addr_i,
  input  cpu_bus_pkg::access_size_e size_i,
  input  cpu_bus_pkg::word_t        wdata_i,
  input  cpu_bus_pkg::bus_beat_u    beat_i,
  output logic [2:0]                axsize_o,
  output cpu_bus_pkg::bus_beat_u    wbeat_o,
  output logic [7:0]                wstrb_o,
  output cpu_bus_pkg::word_t        rword_o
);

  logic [1:0]         byte_off;
  logic [3:0]         size_mask;
  logic [3:0]         lane_strb;
  cpu_bus_pkg::word_t wword;

  assign byte_off = addr_i[1:0];
  assign axsize_o = {1'b0, size_i}; // bytes per beat as log2

  always_comb begin
    case (size_i)
      cpu_bus_pkg::SIZE_BYTE: size_mask = 4'b0001;
      cpu_bus_pkg::SIZE_HALF: size_mask = 4'b0011;
      default:                size_mask = 4'b1111;
    endcase
  end

  // store data moves up to its byte offset, same copy in both lanes
  assign wword         = wdata_i << {byte_off, 3'b000};
  assign wbeat_o.lanes = {wword, wword};

  assign lane_strb = size_mask << byte_off;
  assign wstrb_o   = addr_i[2] ? {lane_strb, 4'b0000} : {4'b0000, lane_strb};

  // load word is the whole lane, byte extract is left to the core
  assign rword_o = beat_i.lanes[addr_i[2]];

endmodule

// ==== design/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

  typedef struct packed {
    addr_t        addr;
    access_size_e size;
    logic         write;
    word_t        wdata;
  } lsu_req_t;

  // one 64-bit beat, seen as two words or as eight bytes
  typedef union packed {
    word_t [1:0]      lanes;
    logic [7:0][7:0] bytes;
  } bus_beat_u;

  typedef struct packed {
    addr_t       addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic [1:0]  burst;
    logic [3:0]  id;
  } axi_ar_t;

  typedef axi_ar_t axi_aw_t; // same layout

  typedef struct packed {
    bus_beat_u  data;
    logic [7:0] strb;
    logic       last;
  } axi_w_t;

  typedef struct packed {
    bus_beat_u  data;
    logic [1:0] resp;
    logic       last;
    logic [3:0] id;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
    logic [3:0] id;
  } axi_b_t;

  // core-local timer, lsu reads only
  localparam addr_t MTIME_LO_ADDR = 32'h0200_bff8;
  localparam addr_t MTIME_HI_ADDR = 32'h0200_bffc;

  localparam int SRAM_WORD_BITS = 9;                    // 64-bit word index
  localparam int SRAM_WORDS     = 1 << SRAM_WORD_BITS;

  localparam logic [3:0] AXI_ID_CORE    = 4'd0;
  localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

endpackage
